// ==== Bender.yml ====
package:
  name: pvr_ctrl

sources:
  - common/pvr_reg_pkg.sv
  - common/pvr_vram_pkg.sv
  - common/reg_access_if.sv
  - common/vram_req_if.sv
  - hw/regs/pvr_reg_decode.sv
  - hw/regs/pvr_reg_store.sv
  - hw/regs/pvr_read_mux.sv
  - hw/vram/vram_owner_arbiter.sv
  - hw/pvr_ctrl.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/pvr_ctrl_sva.sv
      - tb/pvr_ctrl_tb.sv

// ==== common/pvr_reg_pkg.sv ====
package pvr_reg_pkg;

	typedef logic [15:0] reg_addr_t; // host byte address
	typedef logic [31:0] reg_word_t; // one register word

	// writable registers, also the index into the register array
	typedef enum logic [3:0] {
		reg_softreset,     // core and ta soft reset
		reg_startrender,   // drawing start
		reg_fb_x_clip,     // pixel clip x
		reg_fb_y_clip,     // pixel clip y
		reg_isp_backgnd_d, // background surface depth
		reg_isp_backgnd_t, // background surface tag
		reg_vo_control,    // video output control
		reg_ta_ol_base,    // object list base
		reg_ta_isp_base    // isp/tsp param base
	} pvr_reg_e;

	localparam int num_wr_regs = 9;

	// writable register addresses
	localparam reg_addr_t softreset_addr     = 16'h0008;
	localparam reg_addr_t startrender_addr   = 16'h0014;
	localparam reg_addr_t fb_x_clip_addr     = 16'h0068;
	localparam reg_addr_t fb_y_clip_addr     = 16'h006C;
	localparam reg_addr_t isp_backgnd_d_addr = 16'h0088;
	localparam reg_addr_t isp_backgnd_t_addr = 16'h008C;
	localparam reg_addr_t vo_control_addr    = 16'h00E8;
	localparam reg_addr_t ta_ol_base_addr    = 16'h0124;
	localparam reg_addr_t ta_isp_base_addr   = 16'h0128;

	// read-only words and mirrors of outside config
	localparam reg_addr_t id_addr            = 16'h0000;
	localparam reg_addr_t revision_addr      = 16'h0004;
	localparam reg_addr_t param_base_addr    = 16'h0020;
	localparam reg_addr_t region_base_addr   = 16'h002C;
	localparam reg_addr_t fpu_param_cfg_addr = 16'h007C;
	localparam reg_addr_t text_control_addr  = 16'h00E4;

	// where a host read takes its data from
	typedef enum logic [3:0] {
		none,                 // unmapped, dout holds
		store,                // writable register
		palette,              // palette ram word
		id,
		revision,
		mirror_param_base,    // 0x0020
		mirror_region_base,   // 0x002C
		mirror_fpu_param_cfg, // 0x007C
		mirror_text_control   // 0x00E4
	} read_src_e;

	localparam reg_word_t id_value        = 32'h17FD11DB; // device id
	localparam reg_word_t revision_value  = 32'h00000011;
	localparam reg_word_t reg_reset_value = 32'h00000000; // all writable regs

	// palette window is 0x1000..0x1FFC
	localparam logic [3:0] palette_base_nibble = 4'h1;

endpackage

// ==== common/pvr_vram_pkg.sv ====
package pvr_vram_pkg;

	typedef logic [23:0] vram_addr_t; // engine side vram address
	typedef logic [63:0] vram_word_t; // full vram data bus
	typedef logic [31:0] lane_word_t; // one 32-bit lane
	typedef logic [7:0]  burst_cnt_t;

	// address bit that picks the upper lane of vram_din
	localparam int lane_sel_bit = 22;

	// only the low 4MB of each half reaches the bus
	localparam int owned_addr_bits = 22;

endpackage

// ==== common/reg_access_if.sv ====
interface reg_access_if #(
	parameter int palette_entries = 1024
);
	import pvr_reg_pkg::*;

	localparam int pal_idx_w = $clog2(palette_entries);

	logic                 wr_en;     // write to a writable register
	logic                 pal_wr_en; // write to palette ram
	logic                 rd_en;     // qualified host read
	pvr_reg_e             reg_index;
	logic [pal_idx_w-1:0] pal_index; // word address mod palette size
	reg_word_t            wdata;
	read_src_e            read_src;

	modport decoder (
		output wr_en, pal_wr_en, rd_en, reg_index, pal_index, wdata, read_src
	);

	modport store (
		input wr_en, pal_wr_en, rd_en, reg_index, pal_index, wdata, read_src
	);

endinterface

// ==== common/vram_req_if.sv ====
interface vram_req_if;
	import pvr_vram_pkg::*;

	logic       rd;
	logic       wr;
	vram_addr_t addr;
	lane_word_t dout;      // write data from the engine
	burst_cnt_t burst_cnt; // unused by the region-array engine
	lane_word_t din_lane;  // read lane picked by addr bit 22

	modport engine (
		output rd, wr, addr, dout, burst_cnt,
		input  din_lane
	);

	modport arbiter (
		input  rd, wr, addr, dout, burst_cnt,
		output din_lane
	);

endinterface

// ==== compile.f ====
common/pvr_reg_pkg.sv
common/pvr_vram_pkg.sv
common/reg_access_if.sv
common/vram_req_if.sv
hw/regs/pvr_reg_decode.sv
hw/regs/pvr_reg_store.sv
hw/regs/pvr_read_mux.sv
hw/vram/vram_owner_arbiter.sv
hw/pvr_ctrl.sv
tb/tb_clock_gen.sv
tb/pvr_ctrl_sva.sv
tb/pvr_ctrl_tb.sv

// ==== hw/pvr_ctrl.sv ====
module pvr_ctrl #(
	parameter int palette_entries = 1024 // power of two, up to 1024
) (
	input  logic                     clock,
	input  logic                     reset_n,
	input  logic                     pvr_reg_cs,
	input  pvr_reg_pkg::reg_addr_t   pvr_addr,
	input  pvr_reg_pkg::reg_word_t   pvr_din,
	input  logic                     pvr_rd,
	input  logic                     pvr_wr,
	output pvr_reg_pkg::reg_word_t   pvr_dout,
	input  pvr_reg_pkg::reg_word_t   param_base,
	input  pvr_reg_pkg::reg_word_t   region_base,
	input  pvr_reg_pkg::reg_word_t   fpu_param_cfg,
	input  pvr_reg_pkg::reg_word_t   text_control,
	output pvr_reg_pkg::reg_word_t   isp_backgnd_d,
	output pvr_reg_pkg::reg_word_t   isp_backgnd_t,
	output pvr_reg_pkg::reg_word_t   fb_x_clip,
	output pvr_reg_pkg::reg_word_t   fb_y_clip,
	input  logic                     isp_render_start,
	input  logic                     isp_render_done,
	input  logic                     ra_vram_rd,
	input  logic                     ra_vram_wr,
	input  pvr_vram_pkg::vram_addr_t ra_vram_addr,
	input  pvr_vram_pkg::lane_word_t ra_vram_dout,
	output pvr_vram_pkg::lane_word_t ra_vram_din,
	input  logic                     isp_vram_rd,
	input  logic                     isp_vram_wr,
	input  pvr_vram_pkg::vram_addr_t isp_vram_addr,
	input  pvr_vram_pkg::lane_word_t isp_vram_dout,
	input  pvr_vram_pkg::burst_cnt_t isp_vram_burst_cnt,
	output pvr_vram_pkg::lane_word_t isp_vram_din,
	input  pvr_vram_pkg::vram_word_t vram_din,
	output logic                     vram_rd,
	output logic                     vram_wr,
	output pvr_vram_pkg::vram_addr_t vram_addr,
	output pvr_vram_pkg::burst_cnt_t vram_burst_cnt,
	output pvr_vram_pkg::vram_word_t vram_dout
);
	import pvr_reg_pkg::*;

	logic      rd_valid; // store to read mux
	read_src_e rd_src;
	reg_word_t rd_word;

	reg_access_if #(.palette_entries(palette_entries)) acc ();
	vram_req_if ra_req ();
	vram_req_if isp_req ();

	// region-array engine, burst count fixed in the arbiter
	assign ra_req.rd    = ra_vram_rd;
	assign ra_req.wr    = ra_vram_wr;
	assign ra_req.addr  = ra_vram_addr;
	assign ra_req.dout  = ra_vram_dout;
	assign ra_vram_din  = ra_req.din_lane;

	assign isp_req.rd        = isp_vram_rd;
	assign isp_req.wr        = isp_vram_wr;
	assign isp_req.addr      = isp_vram_addr;
	assign isp_req.dout      = isp_vram_dout;
	assign isp_req.burst_cnt = isp_vram_burst_cnt;
	assign isp_vram_din      = isp_req.din_lane;

	pvr_reg_decode #(.palette_entries(palette_entries)) pvr_reg_decode_inst (
		.addr  (pvr_addr),
		.cs    (pvr_reg_cs),
		.rd    (pvr_rd),
		.wr    (pvr_wr),
		.wdata (pvr_din),
		.acc   (acc)
	);

	pvr_reg_store #(.palette_entries(palette_entries)) pvr_reg_store_inst (
		.clock         (clock),
		.reset_n       (reset_n),
		.acc           (acc),
		.rd_valid      (rd_valid),
		.rd_src        (rd_src),
		.rd_word       (rd_word),
		.isp_backgnd_d (isp_backgnd_d),
		.isp_backgnd_t (isp_backgnd_t),
		.fb_x_clip     (fb_x_clip),
		.fb_y_clip     (fb_y_clip)
	);

	pvr_read_mux pvr_read_mux_inst (
		.clock         (clock),
		.reset_n       (reset_n),
		.rd_valid      (rd_valid),
		.rd_src        (rd_src),
		.rd_word       (rd_word),
		.param_base    (param_base),
		.region_base   (region_base),
		.fpu_param_cfg (fpu_param_cfg),
		.text_control  (text_control),
		.pvr_dout      (pvr_dout)
	);

	vram_owner_arbiter vram_owner_arbiter_inst (
		.clock            (clock),
		.reset_n          (reset_n),
		.isp_render_start (isp_render_start),
		.isp_render_done  (isp_render_done),
		.ra_req           (ra_req),
		.isp_req          (isp_req),
		.vram_din         (vram_din),
		.vram_rd          (vram_rd),
		.vram_wr          (vram_wr),
		.vram_addr        (vram_addr),
		.vram_burst_cnt   (vram_burst_cnt),
		.vram_dout        (vram_dout)
	);

endmodule

// ==== hw/regs/pvr_read_mux.sv ====
module pvr_read_mux (
	input  logic                   clock,
	input  logic                   reset_n,
	input  logic                   rd_valid,
	input  pvr_reg_pkg::read_src_e rd_src,
	input  pvr_reg_pkg::reg_word_t rd_word,
	input  pvr_reg_pkg::reg_word_t param_base,    // mirrored at 0x0020
	input  pvr_reg_pkg::reg_word_t region_base,   // 0x002C
	input  pvr_reg_pkg::reg_word_t fpu_param_cfg, // 0x007C
	input  pvr_reg_pkg::reg_word_t text_control,  // 0x00E4
	output pvr_reg_pkg::reg_word_t pvr_dout
);
	import pvr_reg_pkg::*;

	// second read stage, dout only moves when a read completes
	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			pvr_dout <= '0;
		end else if (rd_valid) begin
			case (rd_src)
				store:                pvr_dout <= rd_word;
				palette:              pvr_dout <= rd_word;
				id:                   pvr_dout <= id_value;
				revision:             pvr_dout <= revision_value;
				mirror_param_base:    pvr_dout <= param_base;    // sampled now
				mirror_region_base:   pvr_dout <= region_base;
				mirror_fpu_param_cfg: pvr_dout <= fpu_param_cfg;
				mirror_text_control:  pvr_dout <= text_control;
				default:              pvr_dout <= pvr_dout;      // none, hold
			endcase
		end
	end

endmodule

// ==== hw/regs/pvr_reg_decode.sv ====
module pvr_reg_decode #(
	parameter int palette_entries = 1024
) (
	input  pvr_reg_pkg::reg_addr_t addr,
	input  logic                   cs,
	input  logic                   rd,
	input  logic                   wr,
	input  pvr_reg_pkg::reg_word_t wdata,
	reg_access_if.decoder          acc
);
	import pvr_reg_pkg::*;

	localparam int pal_idx_w = $clog2(palette_entries);

	logic     pal_hit; // address falls in palette window
	logic     reg_hit; // address is a writable register
	pvr_reg_e reg_idx;

	assign pal_hit = (addr[15:12] == palette_base_nibble);

	// writable register match
	always_comb begin
		reg_hit = 1'b1;
		reg_idx = reg_softreset;
		case (addr)
			softreset_addr:     reg_idx = reg_softreset;
			startrender_addr:   reg_idx = reg_startrender;
			fb_x_clip_addr:     reg_idx = reg_fb_x_clip;
			fb_y_clip_addr:     reg_idx = reg_fb_y_clip;
			isp_backgnd_d_addr: reg_idx = reg_isp_backgnd_d;
			isp_backgnd_t_addr: reg_idx = reg_isp_backgnd_t;
			vo_control_addr:    reg_idx = reg_vo_control;
			ta_ol_base_addr:    reg_idx = reg_ta_ol_base;
			ta_isp_base_addr:   reg_idx = reg_ta_isp_base;
			default:            reg_hit = 1'b0; // read-only or unmapped
		endcase
	end

	// classify the read
	always_comb begin
		if (pal_hit) begin
			acc.read_src = palette;
		end else if (reg_hit) begin
			acc.read_src = store;
		end else begin
			case (addr)
				id_addr:            acc.read_src = id;
				revision_addr:      acc.read_src = revision;
				param_base_addr:    acc.read_src = mirror_param_base;
				region_base_addr:   acc.read_src = mirror_region_base;
				fpu_param_cfg_addr: acc.read_src = mirror_fpu_param_cfg;
				text_control_addr:  acc.read_src = mirror_text_control;
				default:            acc.read_src = none; // dout holds
			endcase
		end
	end

	assign acc.wr_en     = cs & wr & reg_hit; // ro and unmapped writes dropped
	assign acc.pal_wr_en = cs & wr & pal_hit;
	assign acc.rd_en     = cs & rd;
	assign acc.reg_index = reg_idx;
	assign acc.pal_index = addr[pal_idx_w+1:2]; // byte to word address, wraps
	assign acc.wdata     = wdata;

endmodule

// ==== hw/regs/pvr_reg_store.sv ====
module pvr_reg_store #(
	parameter int palette_entries = 1024
) (
	input  logic                    clock,
	input  logic                    reset_n,
	reg_access_if.store             acc,
	output logic                    rd_valid, // read word ready this cycle
	output pvr_reg_pkg::read_src_e  rd_src,
	output pvr_reg_pkg::reg_word_t  rd_word,
	output pvr_reg_pkg::reg_word_t  isp_backgnd_d,
	output pvr_reg_pkg::reg_word_t  isp_backgnd_t,
	output pvr_reg_pkg::reg_word_t  fb_x_clip,
	output pvr_reg_pkg::reg_word_t  fb_y_clip
);
	import pvr_reg_pkg::*;

	reg_word_t regs    [num_wr_regs];     // writable registers
	reg_word_t pal_ram [palette_entries]; // palette, no reset
	reg_word_t reg_q;                     // registered register read
	reg_word_t pal_q;                     // registered palette read

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			regs <= '{default: reg_reset_value};
		end else if (acc.wr_en) begin
			regs[acc.reg_index] <= acc.wdata;
		end
	end

	always_ff @(posedge clock) begin
		if (acc.pal_wr_en) begin
			pal_ram[acc.pal_index] <= acc.wdata;
		end
	end

	// first read stage, sees the value before a same-cycle write
	always_ff @(posedge clock) begin
		if (acc.rd_en) begin
			reg_q <= regs[acc.reg_index];
			pal_q <= pal_ram[acc.pal_index];
		end
	end

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			rd_valid <= 1'b0;
			rd_src   <= none;
		end else begin
			rd_valid <= acc.rd_en;
			if (acc.rd_en) rd_src <= acc.read_src; // tag follows its word
		end
	end

	assign rd_word = (rd_src == palette) ? pal_q : reg_q;

	// values the rendering core uses
	assign isp_backgnd_d = regs[reg_isp_backgnd_d];
	assign isp_backgnd_t = regs[reg_isp_backgnd_t];
	assign fb_x_clip     = regs[reg_fb_x_clip];
	assign fb_y_clip     = regs[reg_fb_y_clip];

endmodule

// ==== hw/vram/vram_owner_arbiter.sv ====
module vram_owner_arbiter (
	input  logic                     clock,
	input  logic                     reset_n,
	input  logic                     isp_render_start,
	input  logic                     isp_render_done,
	vram_req_if.arbiter              ra_req,
	vram_req_if.arbiter              isp_req,
	input  pvr_vram_pkg::vram_word_t vram_din,
	output logic                     vram_rd,
	output logic                     vram_wr,
	output pvr_vram_pkg::vram_addr_t vram_addr,
	output pvr_vram_pkg::burst_cnt_t vram_burst_cnt,
	output pvr_vram_pkg::vram_word_t vram_dout
);
	import pvr_vram_pkg::*;

	localparam int addr_pad_w = $bits(vram_addr_t) - owned_addr_bits;
	localparam int dout_pad_w = $bits(vram_word_t) - $bits(lane_word_t);

	logic       isp_owns; // 0 means region-array engine has the bus
	vram_addr_t owner_addr;
	lane_word_t owner_dout;

	// lane picked by the engine's own address
	function automatic lane_word_t pick_lane(input vram_addr_t a, input vram_word_t d);
		return a[lane_sel_bit] ? d[63:32] : d[31:0];
	endfunction

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			isp_owns <= 1'b0;
		end else if (isp_render_done) begin
			isp_owns <= 1'b0; // done wins over start
		end else if (isp_render_start) begin
			isp_owns <= 1'b1;
		end
	end

	assign owner_addr = isp_owns ? isp_req.addr : ra_req.addr;
	assign owner_dout = isp_owns ? isp_req.dout : ra_req.dout;

	assign vram_rd        = isp_owns ? isp_req.rd : ra_req.rd;
	assign vram_wr        = isp_owns ? isp_req.wr : ra_req.wr;
	assign vram_addr      = {{addr_pad_w{1'b0}}, owner_addr[owned_addr_bits-1:0]};
	assign vram_burst_cnt = isp_owns ? isp_req.burst_cnt : burst_cnt_t'(1); // ra single word
	assign vram_dout      = {{dout_pad_w{1'b0}}, owner_dout}; // low lane only

	assign ra_req.din_lane  = pick_lane(ra_req.addr, vram_din);
	assign isp_req.din_lane = pick_lane(isp_req.addr, vram_din);

endmodule

// ==== tb/pvr_ctrl_sva.sv ====
module pvr_ctrl_sva (
	input logic                     clock,
	input logic                     reset_n,
	input logic                     pvr_reg_cs,
	input logic                     pvr_rd,
	input pvr_reg_pkg::reg_word_t   pvr_dout,
	input logic                     ra_vram_rd,
	input logic                     ra_vram_wr,
	input logic                     isp_render_start,
	input logic                     isp_render_done,
	input logic                     vram_rd,
	input logic                     vram_wr,
	input pvr_vram_pkg::burst_cnt_t vram_burst_cnt
);
	timeunit 1ns;
	timeprecision 100ps;

	logic isp_owns_exp;   // owner expected from start and done
	int   fail_count = 0; // failed assertions, read by the testbench

	// ownership follows the render strobes, done wins over start
	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			isp_owns_exp <= 1'b0;
		end else if (isp_render_done) begin
			isp_owns_exp <= 1'b0;
		end else if (isp_render_start) begin
			isp_owns_exp <= 1'b1;
		end
	end

	bus_one_dir: assert property (@(posedge clock) disable iff (!reset_n)
		!(vram_rd && vram_wr))
		else begin
			$error("vram_rd and vram_wr are high in the same cycle");
			fail_count++;
		end

	// region-array engine always moves one word
	ra_single_burst: assert property (@(posedge clock) disable iff (!reset_n)
		(!isp_owns_exp && (ra_vram_rd || ra_vram_wr)) |-> (vram_burst_cnt == 8'd1))
		else begin
			$error("vram_burst_cnt is not 1 while the region-array engine owns the bus");
			fail_count++;
		end

	// read latency is two cycles and nothing else moves dout
	dout_hold: assert property (@(posedge clock) disable iff (!reset_n)
		!$past(pvr_reg_cs && pvr_rd, 2) |-> $stable(pvr_dout))
		else begin
			$error("pvr_dout changed without a read two cycles earlier");
			fail_count++;
		end

endmodule

bind pvr_ctrl pvr_ctrl_sva pvr_ctrl_sva_inst (
	.clock            (clock),
	.reset_n          (reset_n),
	.pvr_reg_cs       (pvr_reg_cs),
	.pvr_rd           (pvr_rd),
	.pvr_dout         (pvr_dout),
	.ra_vram_rd       (ra_vram_rd),
	.ra_vram_wr       (ra_vram_wr),
	.isp_render_start (isp_render_start),
	.isp_render_done  (isp_render_done),
	.vram_rd          (vram_rd),
	.vram_wr          (vram_wr),
	.vram_burst_cnt   (vram_burst_cnt)
);

// ==== tb/pvr_ctrl_tb.sv ====
module pvr_ctrl_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import pvr_reg_pkg::*;
	import pvr_vram_pkg::*;

	localparam int clk_period_ns = 4;
	localparam int test_cycles   = 4 + 30 + 70 + 80 + 20 + 30; // reset, then tests 1 to 5
	localparam int margin_cycles = 50;

	// writable register addresses in map order
	localparam reg_addr_t wr_addrs [num_wr_regs] = '{
		16'h0008, 16'h0014, 16'h0068, 16'h006C, 16'h0088,
		16'h008C, 16'h00E8, 16'h0124, 16'h0128
	};

	logic       clock, reset_n;
	logic       pvr_reg_cs, pvr_rd, pvr_wr;
	reg_addr_t  pvr_addr;
	reg_word_t  pvr_din, pvr_dout;
	reg_word_t  param_base, region_base, fpu_param_cfg, text_control;
	reg_word_t  isp_backgnd_d, isp_backgnd_t, fb_x_clip, fb_y_clip;
	logic       isp_render_start, isp_render_done;
	logic       ra_vram_rd, ra_vram_wr, isp_vram_rd, isp_vram_wr, vram_rd, vram_wr;
	vram_addr_t ra_vram_addr, isp_vram_addr, vram_addr;
	lane_word_t ra_vram_dout, ra_vram_din, isp_vram_dout, isp_vram_din;
	burst_cnt_t isp_vram_burst_cnt, vram_burst_cnt;
	vram_word_t vram_din, vram_dout;

	reg_word_t  reg_model [num_wr_regs]; // expected register contents
	reg_word_t  pal_model [int];         // expected palette, by word index
	reg_addr_t  pal_addrs [$];           // palette addresses written
	integer     seed;
	int         n_checks, n_errors;

	tb_clock_gen #(.period_ns(clk_period_ns), .reset_cycles(4)) clock_gen_inst (
		.clock   (clock),
		.reset_n (reset_n)
	);

	pvr_ctrl pvr_ctrl_inst (.*);

	task automatic check_word(input string name, input logic [63:0] got, input logic [63:0] exp);
		n_checks++;
		assert (got === exp) else begin
			n_errors++;
			$display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	// one host write cycle, entered on a falling edge
	task automatic host_write(input reg_addr_t a, input reg_word_t d);
		pvr_reg_cs = 1'b1;
		pvr_wr     = 1'b1;
		pvr_addr   = a;
		pvr_din    = d;
		@(negedge clock);
		pvr_reg_cs = 1'b0;
		pvr_wr     = 1'b0;
	endtask

	task automatic host_read_check(input reg_addr_t a, input reg_word_t exp);
		pvr_reg_cs = 1'b1;
		pvr_rd     = 1'b1;
		pvr_addr   = a;
		@(negedge clock);
		pvr_reg_cs = 1'b0;
		pvr_rd     = 1'b0;
		@(negedge clock); // dout moved on the second rising edge
		check_word($sformatf("pvr_dout[%h]", a), pvr_dout, exp);
	endtask

	// owner's request on the bus, addr cut to 22 bits, dout in the low lane
	task automatic check_vram_bus(input bit isp_owner);
		check_word("vram_rd", vram_rd, isp_owner ? isp_vram_rd : ra_vram_rd);
		check_word("vram_wr", vram_wr, isp_owner ? isp_vram_wr : ra_vram_wr);
		check_word("vram_addr", vram_addr,
			(isp_owner ? isp_vram_addr : ra_vram_addr) & 24'h3F_FFFF);
		check_word("vram_burst_cnt", vram_burst_cnt, isp_owner ? isp_vram_burst_cnt : 8'd1);
		check_word("vram_dout", vram_dout, {32'h0, isp_owner ? isp_vram_dout : ra_vram_dout});
	endtask

	task automatic reset_state_test();
		check_word("pvr_dout", pvr_dout, 32'h0);
		check_word("isp_backgnd_d", isp_backgnd_d, 32'h0);
		check_word("isp_backgnd_t", isp_backgnd_t, 32'h0);
		check_word("fb_x_clip", fb_x_clip, 32'h0);
		check_word("fb_y_clip", fb_y_clip, 32'h0);
		host_read_check(16'h0000, 32'h17FD11DB); // id
		host_read_check(16'h0004, 32'h00000011); // revision
		for (int i = 0; i < num_wr_regs; i++)
			host_read_check(wr_addrs[i], 32'h0);
		ra_vram_rd   = 1'b1;
		ra_vram_addr = 24'($random(seed));
		ra_vram_dout = $random(seed);
		@(negedge clock);
		check_vram_bus(1'b0); // region-array owns after reset
	endtask

	task automatic register_rw_test();
		for (int i = 0; i < num_wr_regs; i++) begin
			reg_model[i] = $random(seed);
			host_write(wr_addrs[i], reg_model[i]);
			host_read_check(wr_addrs[i], reg_model[i]);
		end
		check_word("fb_x_clip", fb_x_clip, reg_model[2]);
		check_word("fb_y_clip", fb_y_clip, reg_model[3]);
		check_word("isp_backgnd_d", isp_backgnd_d, reg_model[4]);
		check_word("isp_backgnd_t", isp_backgnd_t, reg_model[5]);
		host_write(16'h0000, $random(seed)); // id is read-only
		host_write(16'h0004, $random(seed));
		host_write(16'h0040, $random(seed)); // unmapped
		host_read_check(16'h0000, 32'h17FD11DB);
		host_read_check(16'h0004, 32'h00000011);
		for (int i = 0; i < num_wr_regs; i++)
			host_read_check(wr_addrs[i], reg_model[i]);
	endtask

	task automatic palette_test();
		int        idx;
		reg_addr_t a;
		repeat (16) begin
			idx = $random(seed) & 32'h3FF; // 1024 entries
			a   = 16'h1000 | reg_addr_t'(idx << 2);
			pal_model[idx] = $random(seed);
			pal_addrs.push_back(a);
			host_write(a, pal_model[idx]);
		end
		foreach (pal_addrs[i])
			host_read_check(pal_addrs[i], pal_model[pal_addrs[i][11:2]]);
		// one read per cycle, each word lands two cycles after its read
		for (int i = 0; i < pal_addrs.size() + 2; i++) begin
			if (i >= 2) begin
				a = pal_addrs[i - 2];
				check_word($sformatf("pvr_dout[%h] in a burst", a), pvr_dout, pal_model[a[11:2]]);
			end
			pvr_reg_cs = (i < pal_addrs.size());
			pvr_rd     = (i < pal_addrs.size());
			if (i < pal_addrs.size())
				pvr_addr = pal_addrs[i];
			@(negedge clock);
		end
	endtask

	task automatic mirror_hold_test();
		param_base    = $random(seed);
		region_base   = $random(seed);
		fpu_param_cfg = $random(seed);
		text_control  = $random(seed);
		host_read_check(16'h0020, param_base);
		host_read_check(16'h002C, region_base);
		host_read_check(16'h007C, fpu_param_cfg);
		host_read_check(16'h00E4, text_control);
		param_base = $random(seed); // mirror tracks the live input
		host_read_check(16'h0020, param_base);
		host_read_check(16'h0040, param_base); // unmapped read, dout holds
	endtask

	task automatic vram_ownership_test();
		ra_vram_rd         = 1'b1;
		ra_vram_wr         = 1'b0;
		ra_vram_addr       = 24'hC0_0000 | 24'($random(seed)); // bits 23:22 set
		ra_vram_dout       = $random(seed);
		isp_vram_rd        = 1'b0;
		isp_vram_wr        = 1'b1;
		isp_vram_addr      = 24'($random(seed));
		isp_vram_dout      = $random(seed);
		isp_vram_burst_cnt = 8'd8;
		@(negedge clock);
		check_vram_bus(1'b0);
		isp_render_start = 1'b1;
		@(negedge clock);
		isp_render_start = 1'b0;
		check_vram_bus(1'b1);
		@(negedge clock);
		check_vram_bus(1'b1); // isp keeps it until done
		isp_render_done = 1'b1;
		@(negedge clock);
		isp_render_done = 1'b0;
		check_vram_bus(1'b0);
		isp_render_start = 1'b1;
		isp_render_done  = 1'b1;
		@(negedge clock);
		isp_render_start = 1'b0;
		isp_render_done  = 1'b0;
		check_vram_bus(1'b0); // done wins
		vram_din          = {$random(seed), $random(seed)};
		ra_vram_addr[22]  = 1'b1;
		isp_vram_addr[22] = 1'b0;
		@(negedge clock);
		check_word("ra_vram_din", ra_vram_din, vram_din[63:32]);
		check_word("isp_vram_din", isp_vram_din, vram_din[31:0]);
		ra_vram_addr[22]  = 1'b0;
		isp_vram_addr[22] = 1'b1;
		@(negedge clock);
		check_word("ra_vram_din", ra_vram_din, vram_din[31:0]);
		check_word("isp_vram_din", isp_vram_din, vram_din[63:32]);
	endtask

	initial begin
		seed               = 32'h7bac;
		n_checks           = 0;
		n_errors           = 0;
		pvr_reg_cs         = 1'b0;
		pvr_rd             = 1'b0;
		pvr_wr             = 1'b0;
		pvr_addr           = '0;
		pvr_din            = '0;
		param_base         = '0;
		region_base        = '0;
		fpu_param_cfg      = '0;
		text_control       = '0;
		isp_render_start   = 1'b0;
		isp_render_done    = 1'b0;
		ra_vram_rd         = 1'b0;
		ra_vram_wr         = 1'b0;
		ra_vram_addr       = '0;
		ra_vram_dout       = '0;
		isp_vram_rd        = 1'b0;
		isp_vram_wr        = 1'b0;
		isp_vram_addr      = '0;
		isp_vram_dout      = '0;
		isp_vram_burst_cnt = '0;
		vram_din           = '0;
		@(posedge reset_n);
		@(negedge clock);
		reset_state_test();
		register_rw_test();
		palette_test();
		mirror_hold_test();
		vram_ownership_test();
		n_errors += pvr_ctrl_inst.pvr_ctrl_sva_inst.fail_count; // bound assertion failures
		$display("checks %0d errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// watchdog sized from the test budgets above
	initial begin
		#((test_cycles + margin_cycles) * clk_period_ns);
		$display("watchdog expired before the tests finished");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== tb/tb_clock_gen.sv ====
module tb_clock_gen #(
	parameter int period_ns    = 4,
	parameter int reset_cycles = 4
) (
	output logic clock,
	output logic reset_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clock = 1'b0;
		forever #(period_ns / 2) clock = ~clock;
	end

	initial begin
		reset_n = 1'b0; // held low from time zero
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		reset_n = 1'b1; // released away from the rising edge
	end

endmodule
